//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

    ///////////////////////////////////////////////////////////////////////
    // instruction fields
    ///////////////////////////////////////////////////////////////////////

    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;

    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_regimm  = 6'b000001,  // bltz, bgez
        op_j       = 6'b000010,
        op_jal     = 6'b000011,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_blez    = 6'b000110,
        op_bgtz    = 6'b000111,
        op_addi    = 6'b001000,
        op_addiu   = 6'b001001,
        op_slti    = 6'b001010,
        op_sltiu   = 6'b001011,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111,
        op_lb      = 6'b100000,
        op_lh      = 6'b100001,
        op_lw      = 6'b100011,
        op_lbu     = 6'b100100,
        op_lhu     = 6'b100101,
        op_sb      = 6'b101000,
        op_sh      = 6'b101001,
        op_sw      = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'b000000,  // also nop
        fn_srl  = 6'b000010,
        fn_sra  = 6'b000011,
        fn_sllv = 6'b000100,
        fn_srlv = 6'b000110,
        fn_srav = 6'b000111,
        fn_jr   = 6'b001000,
        fn_jalr = 6'b001001,
        fn_add  = 6'b100000,
        fn_addu = 6'b100001,
        fn_sub  = 6'b100010,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_xor  = 6'b100110,
        fn_nor  = 6'b100111,
        fn_slt  = 6'b101010,
        fn_sltu = 6'b101011
    } funct_e;

    ///////////////////////////////////////////////////////////////////////
    // time values, stages counted from decode
    ///////////////////////////////////////////////////////////////////////

    localparam int T_W = 5;

    localparam logic [T_W-1:0] T_USE_D = 5'd0;
    localparam logic [T_W-1:0] T_USE_E = 5'd1;
    localparam logic [T_W-1:0] T_USE_M = 5'd2;
    localparam logic [T_W-1:0] T_NEVER = 5'd31;  // source not read

endpackage

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0000_3000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    output logic [31:0] pc,
    output logic [31:0] pc_plus_4,
    output logic [31:0] pc_plus_8
);

    logic [31:0] pc_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc_q <= RESET_PC;
        end
        else if (!stall)
        begin
            pc_q <= pc_q + 32'd4;  // no branches taken here
        end
    end

    assign pc        = pc_q;
    assign pc_plus_4 = pc_q + 32'd4;
    assign pc_plus_8 = pc_q + 32'd8;  // jal link value

endmodule

`default_nettype wire

//--- reg_if_to_d.sv
`timescale 1ns/1ps
`default_nettype none

module reg_if_to_d (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      en,
    input  logic [31:0]               instr_in,
    input  logic [31:0]               pc_plus_4_in,
    input  logic [31:0]               pc_plus_8_in,
    output logic [31:0]               instr,
    output logic [31:0]               pc_plus_4,
    output logic [31:0]               pc_plus_8,
    output logic [mips_pkg::T_W-1:0]  t_use_rs,
    output logic [mips_pkg::T_W-1:0]  t_use_rt
);

    logic [mips_pkg::T_W-1:0] use_rs_next;
    logic [mips_pkg::T_W-1:0] use_rt_next;

    //////////////////////////////////////////////////////////////////////
    // time-to-use decode of the incoming word
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        use_rs_next = mips_pkg::T_NEVER;  // unknown codes read nothing
        use_rt_next = mips_pkg::T_NEVER;
        case (mips_pkg::opcode_e'(instr_in[31:26]))
            mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti,
            mips_pkg::op_sltiu, mips_pkg::op_andi, mips_pkg::op_ori,
            mips_pkg::op_xori,
            mips_pkg::op_lb, mips_pkg::op_lh, mips_pkg::op_lw,
            mips_pkg::op_lbu, mips_pkg::op_lhu:
            begin
                use_rs_next = mips_pkg::T_USE_E;
            end
            mips_pkg::op_beq, mips_pkg::op_bne, mips_pkg::op_blez,
            mips_pkg::op_bgtz, mips_pkg::op_regimm:
            begin
                use_rs_next = mips_pkg::T_USE_D;  // compared in decode
                use_rt_next = mips_pkg::T_USE_D;
            end
            mips_pkg::op_sb, mips_pkg::op_sh, mips_pkg::op_sw:
            begin
                use_rs_next = mips_pkg::T_USE_E;  // address
                use_rt_next = mips_pkg::T_USE_M;  // store data
            end
            mips_pkg::op_special:
            begin
                case (mips_pkg::funct_e'(instr_in[5:0]))
                    mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub,
                    mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
                    mips_pkg::fn_xor, mips_pkg::fn_nor, mips_pkg::fn_slt,
                    mips_pkg::fn_sltu,
                    mips_pkg::fn_sllv, mips_pkg::fn_srlv, mips_pkg::fn_srav:
                    begin
                        use_rs_next = mips_pkg::T_USE_E;
                        use_rt_next = mips_pkg::T_USE_E;
                    end
                    mips_pkg::fn_srl, mips_pkg::fn_sra:
                    begin
                        use_rt_next = mips_pkg::T_USE_E;  // shamt, no rs
                    end
                    mips_pkg::fn_sll:
                    begin
                        if (instr_in != 32'd0)  // nop reads nothing
                        begin
                            use_rt_next = mips_pkg::T_USE_E;
                        end
                    end
                    mips_pkg::fn_jr, mips_pkg::fn_jalr:
                    begin
                        use_rs_next = mips_pkg::T_USE_D;  // target in decode
                    end
                    default:
                    begin
                        use_rs_next = mips_pkg::T_NEVER;
                    end
                endcase
            end
            default:  // lui, j, jal and unknown codes
            begin
                use_rs_next = mips_pkg::T_NEVER;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // pipeline register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            instr     <= 32'd0;
            pc_plus_4 <= 32'd0;
            pc_plus_8 <= 32'd0;
            t_use_rs  <= '0;
            t_use_rt  <= '0;
        end
        else if (en)
        begin
            instr     <= instr_in;
            pc_plus_4 <= pc_plus_4_in;
            pc_plus_8 <= pc_plus_8_in;
            t_use_rs  <= use_rs_next;
            t_use_rt  <= use_rt_next;
        end
    end

endmodule

`default_nettype wire

//--- reg_d_to_e.sv
`timescale 1ns/1ps
`default_nettype none

module reg_d_to_e (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic [31:0]               instr_in,
    output logic [31:0]               instr,
    output logic [4:0]                dst,
    output logic [mips_pkg::T_W-1:0]  t_new
);

    logic [4:0]               rt;
    logic [4:0]               rd;
    logic [4:0]               dst_next;
    logic [mips_pkg::T_W-1:0] t_new_next;

    assign rt = instr_in[mips_pkg::RT_LSB +: 5];
    assign rd = instr_in[mips_pkg::RD_LSB +: 5];

    // destination and execute-stage cycles until the result exists
    always_comb
    begin
        dst_next   = 5'd0;
        t_new_next = '0;
        case (mips_pkg::opcode_e'(instr_in[31:26]))
            mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti,
            mips_pkg::op_sltiu, mips_pkg::op_andi, mips_pkg::op_ori,
            mips_pkg::op_xori, mips_pkg::op_lui:
            begin
                dst_next   = rt;
                t_new_next = mips_pkg::T_W'(1);
            end
            mips_pkg::op_lb, mips_pkg::op_lh, mips_pkg::op_lw,
            mips_pkg::op_lbu, mips_pkg::op_lhu:
            begin
                dst_next   = rt;
                t_new_next = mips_pkg::T_W'(2);  // data after memory
            end
            mips_pkg::op_jal:
            begin
                dst_next   = 5'd31;
                t_new_next = mips_pkg::T_W'(1);
            end
            mips_pkg::op_special:
            begin
                case (mips_pkg::funct_e'(instr_in[5:0]))
                    mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub,
                    mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
                    mips_pkg::fn_xor, mips_pkg::fn_nor, mips_pkg::fn_slt,
                    mips_pkg::fn_sltu,
                    mips_pkg::fn_sll, mips_pkg::fn_srl, mips_pkg::fn_sra,
                    mips_pkg::fn_sllv, mips_pkg::fn_srlv, mips_pkg::fn_srav,
                    mips_pkg::fn_jalr:
                    begin
                        dst_next   = rd;  // alu, shifts, jalr
                        t_new_next = mips_pkg::T_W'(1);
                    end
                    default:
                    begin
                        dst_next = 5'd0;  // jr and unknown codes
                    end
                endcase
            end
            default:
            begin
                dst_next = 5'd0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset || stall)  // stall inserts a bubble
        begin
            instr <= 32'd0;
            dst   <= 5'd0;
            t_new <= '0;
        end
        else
        begin
            instr <= instr_in;
            dst   <= dst_next;
            t_new <= t_new_next;
        end
    end

endmodule

`default_nettype wire

//--- reg_e_to_m.sv
`timescale 1ns/1ps
`default_nettype none

module reg_e_to_m (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [4:0]                dst_in,
    input  logic [mips_pkg::T_W-1:0]  t_new_in,
    output logic [4:0]                dst,
    output logic [mips_pkg::T_W-1:0]  t_new
);

    logic [mips_pkg::T_W-1:0] t_new_aged;

    // one stage closer to the result, floored at zero
    assign t_new_aged = (t_new_in == '0) ? '0 : t_new_in - mips_pkg::T_W'(1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dst   <= 5'd0;
            t_new <= '0;
        end
        else
        begin
            dst   <= dst_in;
            t_new <= t_new_aged;
        end
    end

endmodule

`default_nettype wire

//--- stall_unit.sv
`timescale 1ns/1ps
`default_nettype none

module stall_unit (
    input  logic [31:0]               d_instr,
    input  logic [mips_pkg::T_W-1:0]  t_use_rs,
    input  logic [mips_pkg::T_W-1:0]  t_use_rt,
    input  logic [4:0]                dst_e,
    input  logic [4:0]                dst_m,
    input  logic [mips_pkg::T_W-1:0]  t_new_e,
    input  logic [mips_pkg::T_W-1:0]  t_new_m,
    output logic                      stall
);

    logic [4:0] rs;
    logic [4:0] rt;
    logic       stall_rs_e;
    logic       stall_rs_m;
    logic       stall_rt_e;
    logic       stall_rt_m;

    assign rs = d_instr[mips_pkg::RS_LSB +: 5];
    assign rt = d_instr[mips_pkg::RT_LSB +: 5];

    //////////////////////////////////////////////////////////////////////
    // needed sooner than the producer can deliver
    //////////////////////////////////////////////////////////////////////

    assign stall_rs_e = (rs != 5'd0) && (rs == dst_e) && (t_use_rs < t_new_e);
    assign stall_rs_m = (rs != 5'd0) && (rs == dst_m) && (t_use_rs < t_new_m);
    assign stall_rt_e = (rt != 5'd0) && (rt == dst_e) && (t_use_rt < t_new_e);
    assign stall_rt_m = (rt != 5'd0) && (rt == dst_m) && (t_use_rt < t_new_m);

    assign stall = stall_rs_e | stall_rs_m | stall_rt_e | stall_rt_m;

endmodule

`default_nettype wire

//--- pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_3000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic        stall,
    output logic [31:0] d_instr,
    output logic [31:0] e_instr
);

    logic [31:0]               f_pc_plus_4;
    logic [31:0]               f_pc_plus_8;
    logic [31:0]               d_pc_plus_4;  // for later stages
    logic [31:0]               d_pc_plus_8;
    logic [mips_pkg::T_W-1:0]  d_t_use_rs;
    logic [mips_pkg::T_W-1:0]  d_t_use_rt;
    logic [4:0]                e_dst;
    logic [mips_pkg::T_W-1:0]  e_t_new;
    logic [4:0]                m_dst;
    logic [mips_pkg::T_W-1:0]  m_t_new;
    logic                      d_en;

    assign d_en = ~stall;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) i_fetch_unit (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .pc        (pc),
        .pc_plus_4 (f_pc_plus_4),
        .pc_plus_8 (f_pc_plus_8)
    );

    reg_if_to_d i_reg_if_to_d (
        .clk          (clk),
        .reset        (reset),
        .en           (d_en),
        .instr_in     (instr),
        .pc_plus_4_in (f_pc_plus_4),
        .pc_plus_8_in (f_pc_plus_8),
        .instr        (d_instr),
        .pc_plus_4    (d_pc_plus_4),
        .pc_plus_8    (d_pc_plus_8),
        .t_use_rs     (d_t_use_rs),
        .t_use_rt     (d_t_use_rt)
    );

    reg_d_to_e i_reg_d_to_e (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .instr_in (d_instr),
        .instr    (e_instr),
        .dst      (e_dst),
        .t_new    (e_t_new)
    );

    reg_e_to_m i_reg_e_to_m (
        .clk      (clk),
        .reset    (reset),
        .dst_in   (e_dst),
        .t_new_in (e_t_new),
        .dst      (m_dst),
        .t_new    (m_t_new)
    );

    stall_unit i_stall_unit (
        .d_instr  (d_instr),
        .t_use_rs (d_t_use_rs),
        .t_use_rt (d_t_use_rt),
        .dst_e    (e_dst),
        .dst_m    (m_dst),
        .t_new_e  (e_t_new),
        .t_new_m  (m_t_new),
        .stall    (stall)
    );

endmodule

`default_nettype wire

//--- tb_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe;

    localparam logic [31:0] RESET_PC = 32'h0000_3000;

    // instruction kinds for the reference decode
    localparam int K_NONE   = 0;
    localparam int K_IALU   = 1;
    localparam int K_LUI    = 2;
    localparam int K_LOAD   = 3;
    localparam int K_STORE  = 4;
    localparam int K_BRANCH = 5;
    localparam int K_J      = 6;
    localparam int K_JAL    = 7;
    localparam int K_RALU   = 8;
    localparam int K_CSHIFT = 9;
    localparam int K_JR     = 10;
    localparam int K_JALR   = 11;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        stall;
    logic [31:0] d_instr;
    logic [31:0] e_instr;

    logic [31:0] lfsr;
    int          errors;
    bit          use_random;
    logic [31:0] cur_instr;
    logic [31:0] pending[$];

    // reference pipeline state
    logic [31:0] mpc;
    logic [31:0] md_instr;
    logic [4:0]  md_use_rs;
    logic [4:0]  md_use_rt;
    logic [31:0] me_instr;
    logic [4:0]  me_dst;
    logic [4:0]  me_tnew;
    logic [4:0]  mm_dst;
    logic [4:0]  mm_tnew;

    pipe_top #(
        .RESET_PC (RESET_PC)
    ) i_pipe_top (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .pc      (pc),
        .stall   (stall),
        .d_instr (d_instr),
        .e_instr (e_instr)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rnd(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd3, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt);
        return {op, rs, rt, 16'h0010};
    endfunction

    function automatic logic [31:0] random_word();
        logic [3:0] cls;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        cls = 4'(rnd(4));
        rs  = 5'(rnd(2));  // registers 0..3 only
        rt  = 5'(rnd(2));
        rd  = 5'(rnd(2));
        case (cls)
            4'd0:    return r_word(6'h20, rs, rt, rd);  // add
            4'd1:    return r_word(6'h22, rs, rt, rd);
            4'd2:    return r_word(6'h04, rs, rt, rd);  // sllv
            4'd3:    return r_word(6'h02, 5'd0, rt, rd);  // srl
            4'd4:    return i_word(6'h08, rs, rt);
            4'd5:    return i_word(6'h0d, rs, rt);
            4'd6:    return i_word(6'h23, rs, rt);  // lw
            4'd7:    return i_word(6'h20, rs, rt);
            4'd8:    return i_word(6'h2b, rs, rt);  // sw
            4'd9:    return i_word(6'h04, rs, rt);  // beq
            4'd10:   return i_word(6'h07, rs, 5'd0);
            4'd11:   return i_word(6'h0f, 5'd0, rt);  // lui
            4'd12:   return rd[0] ? {6'h03, 26'h40} : {6'h02, 26'h40};
            4'd13:   return r_word(rd[0] ? 6'h09 : 6'h08, rs, 5'd0, rd);
            4'd14:   return 32'd0;
            default: return rd[0] ? r_word(6'h3f, rs, rt, rd) : i_word(6'h3f, rs, rt);
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference decode
    //////////////////////////////////////////////////////////////////////

    function automatic int kind_of(input logic [31:0] w);
        if (w == 32'd0)
            return K_NONE;  // nop
        case (w[31:26])
            6'h00:
            begin
                case (w[5:0])
                    6'h00, 6'h02, 6'h03: return K_CSHIFT;
                    6'h04, 6'h06, 6'h07: return K_RALU;
                    6'h08: return K_JR;
                    6'h09: return K_JALR;
                    6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                    6'h2a, 6'h2b: return K_RALU;
                    default: return K_NONE;
                endcase
            end
            6'h01, 6'h04, 6'h05, 6'h06, 6'h07: return K_BRANCH;
            6'h02: return K_J;
            6'h03: return K_JAL;
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e: return K_IALU;
            6'h0f: return K_LUI;
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: return K_LOAD;
            6'h28, 6'h29, 6'h2b: return K_STORE;
            default: return K_NONE;
        endcase
    endfunction

    function automatic logic [4:0] use_rs_of(input logic [31:0] w);
        case (kind_of(w))
            K_IALU, K_LOAD, K_STORE, K_RALU: return 5'd1;
            K_BRANCH, K_JR, K_JALR: return 5'd0;
            default: return 5'd31;
        endcase
    endfunction

    function automatic logic [4:0] use_rt_of(input logic [31:0] w);
        case (kind_of(w))
            K_BRANCH: return 5'd0;
            K_RALU, K_CSHIFT: return 5'd1;
            K_STORE: return 5'd2;
            default: return 5'd31;
        endcase
    endfunction

    function automatic logic [4:0] dst_of(input logic [31:0] w);
        case (kind_of(w))
            K_IALU, K_LUI, K_LOAD: return w[20:16];
            K_RALU, K_CSHIFT, K_JALR: return w[15:11];
            K_JAL: return 5'd31;
            default: return 5'd0;
        endcase
    endfunction

    function automatic logic [4:0] tnew_of(input logic [31:0] w);
        case (kind_of(w))
            K_LOAD: return 5'd2;
            K_IALU, K_LUI, K_RALU, K_CSHIFT, K_JALR, K_JAL: return 5'd1;
            default: return 5'd0;
        endcase
    endfunction

    function automatic bit model_stall();
        logic [4:0] rs;
        logic [4:0] rt;
        bit         hit;
        rs  = md_instr[25:21];
        rt  = md_instr[20:16];
        hit = 1'b0;
        if (rs != 0 && rs == me_dst && md_use_rs < me_tnew) hit = 1'b1;
        if (rs != 0 && rs == mm_dst && md_use_rs < mm_tnew) hit = 1'b1;
        if (rt != 0 && rt == me_dst && md_use_rt < me_tnew) hit = 1'b1;
        if (rt != 0 && rt == mm_dst && md_use_rt < mm_tnew) hit = 1'b1;
        return hit;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checking and cycle stepping
    //////////////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (exp === act)
        else
        begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_outputs();
        check_val("pc", mpc, pc);
        check_val("stall", {31'd0, model_stall()}, {31'd0, stall});
        check_val("d_instr", md_instr, d_instr);
        check_val("e_instr", me_instr, e_instr);
    endtask

    task automatic step();
        bit st;
        @(posedge clk);
        st = model_stall();
        mm_dst  = me_dst;
        mm_tnew = (me_tnew == 0) ? 5'd0 : me_tnew - 5'd1;
        if (st)
        begin
            me_instr = 32'd0;  // bubble
            me_dst   = 5'd0;
            me_tnew  = 5'd0;
        end
        else
        begin
            me_instr  = md_instr;
            me_dst    = dst_of(md_instr);
            me_tnew   = tnew_of(md_instr);
            md_instr  = cur_instr;
            md_use_rs = use_rs_of(cur_instr);
            md_use_rt = use_rt_of(cur_instr);
            mpc       = mpc + 32'd4;
        end
        if (!model_stall())  // a held pc keeps the same word
        begin
            if (pending.size() > 0)
                cur_instr = pending.pop_front();
            else if (use_random)
                cur_instr = random_word();
            else
                cur_instr = 32'd0;
        end
        instr <= cur_instr;
        #1;
        compare_outputs();
    endtask

    // feeds the queued words plus a drain and counts stall cycles
    task automatic run_seq(input string name, input int exp_stalls);
        int stalls;
        int n;
        stalls = 0;
        n = 0;
        repeat (3) pending.push_back(32'd0);
        while (pending.size() > 0 && n < 50)
        begin
            step();
            if (stall)
                stalls++;
            n++;
        end
        if (pending.size() > 0)
        begin
            $display("timeout: sequence %s did not drain", name);
            errors++;
        end
        repeat (3) step();
        check_val(name, exp_stalls, stalls);
    endtask

    initial
    begin
        int n;
        lfsr       = 32'h6661_d9d0;
        errors     = 0;
        use_random = 1'b0;
        reset      = 1'b1;
        instr      = 32'd0;
        cur_instr  = 32'd0;
        mpc        = RESET_PC;
        md_instr   = 32'd0;
        md_use_rs  = 5'd0;
        md_use_rt  = 5'd0;
        me_instr   = 32'd0;
        me_dst     = 5'd0;
        me_tnew    = 5'd0;
        mm_dst     = 5'd0;
        mm_tnew    = 5'd0;

        n = 0;
        while (n < 10)
        begin
            @(posedge clk);
            n++;
        end
        reset <= 1'b0;
        #1;
        compare_outputs();

        // hazard-free stream
        for (int i = 0; i < 6; i++)
            pending.push_back(i_word(6'h08, 5'd0, 5'(i + 1)));
        run_seq("no_hazard", 0);

        pending.push_back(i_word(6'h23, 5'd2, 5'd1));
        pending.push_back(r_word(6'h20, 5'd1, 5'd2, 5'd3));
        run_seq("load_use_alu", 1);

        pending.push_back(i_word(6'h23, 5'd2, 5'd1));
        pending.push_back(i_word(6'h2b, 5'd1, 5'd3));
        run_seq("load_store_addr", 1);

        pending.push_back(i_word(6'h23, 5'd2, 5'd1));
        pending.push_back(i_word(6'h04, 5'd1, 5'd0));
        run_seq("load_branch", 2);

        pending.push_back(r_word(6'h20, 5'd2, 5'd3, 5'd1));
        pending.push_back(i_word(6'h04, 5'd1, 5'd2));
        run_seq("alu_branch", 1);

        pending.push_back(i_word(6'h23, 5'd2, 5'd1));
        pending.push_back(r_word(6'h08, 5'd1, 5'd0, 5'd0));
        run_seq("load_jr", 2);

        pending.push_back(r_word(6'h20, 5'd2, 5'd3, 5'd1));
        pending.push_back(r_word(6'h09, 5'd1, 5'd0, 5'd2));
        run_seq("alu_jalr", 1);

        pending.push_back(i_word(6'h23, 5'd2, 5'd1));
        pending.push_back(i_word(6'h2b, 5'd2, 5'd1));
        run_seq("load_store_data", 0);

        pending.push_back(i_word(6'h23, 5'd2, 5'd0));
        pending.push_back(r_word(6'h20, 5'd0, 5'd0, 5'd3));
        run_seq("reg_zero", 0);

        use_random = 1'b1;
        n = 0;
        while (n < 2000)
        begin
            step();
            n++;
        end

        $display("checks done, errors: %0d", errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
mips_pkg.sv
fetch_unit.sv
reg_if_to_d.sv
reg_d_to_e.sv
reg_e_to_m.sv
stall_unit.sv
pipe_top.sv
tb_pipe.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module tb_pipe -o Vtb_pipe
	@out=$$(./obj_dir/Vtb_pipe); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing -f build.f --top-module tb_pipe

clean:
	rm -rf obj_dir
